// File: vlog.f
arrayPkg.sv
arrayAllocator.sv
arrayDecode.sv
arrayExecute.sv
arrayResult.sv
arrayUnit.sv
arrayUnit_chk.sv
arrayUnitTb.sv

// File: Makefile
# Verilator build and run of the array memory unit testbench

VERILATOR ?= verilator
TOP       ?= arrayUnitTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)

// File: arrayUnitTb.sv
//--------------------------------------------------------------------------
// Array unit testbench
// Directed and random commands checked against a reference model
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module arrayUnitTb;
  import arrayPkg::*;

  localparam int ResetCycles = 8;

  logic     clock;
  logic     reset;
  logic     cmdValid;
  arrayCmd  cmd;
  logic     respValid;
  arrayResp resp;
  integer   seed = 32'h4f61_6a78;
  int       errors = 0;
  int       issued = 0;
  logic     sentValid = 1'b0;                          // cmdValid one cycle back

  logic     mAlloc [ArrayCount];                       // Model of the pool
  int       mHigh;
  arrayId   mStack [$];                                // Freed ids, newest at back
  int       mSize [ArrayCount];
  dataWord  mMem [ArrayCount][ArrayLength];
  logic     mKnown [ArrayCount][ArrayLength];          // Cell written at least once
  arrayResp expQ [$];
  logic     knownQ [$];
  string    nameQ [$];

  arrayUnit dut0 (.clock(clock), .reset(reset), .cmdValid(cmdValid), .cmd(cmd),
                  .respValid(respValid), .resp(resp));

  // ------------------------------------------------------------------------
  // Reference model, one step per command
  // ------------------------------------------------------------------------
  function automatic arrayResp modelStep(input arrayCmd c, output logic known);
    errorKind e;
    int       s;
    int       a;
    int       n;
    dataWord  v;
    dataWord  old;
    dataWord  nv;
    e     = errNone;
    v     = '0;
    known = 1'b1;
    s     = mSize[c.id];
    if (c.op == opAlloc) begin
      if (mStack.size() == 0 && mHigh == ArrayCount) e = errOutOfMemory;
    end else if (c.op != opReset) begin
      if (int'(c.id) >= mHigh) e = errNotAllocated;
      else if (!mAlloc[c.id]) e = errFreed;
      else if (c.op inside {opRead, [opAdd:opAnd]} && int'(c.index) >= s) e = errOutOfBounds;
      else if (c.op inside {opDec, opPop} && s == 0) e = errEmpty;
      else if (c.op inside {opInc, opPush} && s == ArrayLength) e = errFull;
    end
    if (e == errNone) begin
      a     = (c.op == opPush) ? s : ((c.op == opPop) ? s - 1 : int'(c.index));
      old   = mMem[c.id][a];
      known = (c.op inside {opRead, opPop, [opAdd:opAnd]}) ? mKnown[c.id][a] : 1'b1;
      case (c.op)
        opReset: begin
          mHigh = 0;
          mStack.delete();
          for (int i = 0; i < ArrayCount; i++) begin
            mAlloc[i] = 1'b0;
            mSize[i]  = 0;
          end
        end
        opAlloc: begin
          if (mStack.size() != 0) begin
            n = int'(mStack.pop_back());               // LIFO reuse
          end else begin
            n = mHigh;
            mHigh++;
          end
          mAlloc[n] = 1'b1;
          mSize[n]  = 0;
          v = dataWord'(n);
        end
        opFree: begin
          mAlloc[c.id] = 1'b0;
          mSize[c.id]  = 0;
          mStack.push_back(c.id);
        end
        opWrite, opPush: begin
          mMem[c.id][a]   = c.data;
          mKnown[c.id][a] = 1'b1;
          mSize[c.id] = (c.op == opPush) ? s + 1 : ((a + 1 > s) ? a + 1 : s);
          v = (c.op == opPush) ? dataWord'(s + 1) : c.data;
        end
        opRead: v = old;
        opSize: v = dataWord'(s);
        opInc, opDec: begin
          mSize[c.id] = (c.op == opInc) ? s + 1 : s - 1;
          v = dataWord'(mSize[c.id]);
        end
        opPop: begin
          mSize[c.id] = s - 1;
          v = old;
        end
        default: begin
          case (c.op)
            opAdd, opAddAfter: nv = old + c.data;      // Wraps at 12 bits
            opSub, opSubAfter: nv = old - c.data;
            opOr:              nv = old | c.data;
            opXor:             nv = old ^ c.data;
            default:           nv = old & c.data;
          endcase
          mMem[c.id][a] = nv;
          v = (c.op inside {opAddAfter, opSubAfter}) ? old : nv;
        end
      endcase
    end
    return '{value: v, error: e};
  endfunction

  task automatic checkResp(input string name, input arrayResp exp, input arrayResp act,
                           input logic known);
    if (act.error !== exp.error || (known && act.value !== exp.value)) begin
      errors++;
      $display("Error %s: expected %03h %s, actual %03h %s", name, exp.value,
               exp.error.name(), act.value, act.error.name());
    end
  endtask

  task automatic issue(input string name, input arrayOp op, input int id, input int index,
                       input int data);
    arrayCmd  c;
    arrayResp r;
    logic     known;
    c = '{op: op, id: arrayId'(id), index: elemIndex'(index), data: dataWord'(data)};
    r = modelStep(c, known);
    @(posedge clock);
    expQ.push_back(r);
    knownQ.push_back(known);
    nameQ.push_back(name);
    cmdValid <= 1'b1;
    cmd      <= c;
    issued++;
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // ------------------------------------------------------------------------
  // Compare process, samples at the falling edge
  // ------------------------------------------------------------------------
  always @(negedge clock) begin
    if (sentValid && !respValid) begin
      errors++;
      $display("No response strobe for the %s command", nameQ[0]);
      expQ.delete(0);
      knownQ.delete(0);
      nameQ.delete(0);
    end else if (respValid && (!sentValid || expQ.size() == 0)) begin
      errors++;
      $display("Response strobe arrived without a command");
    end else if (respValid) begin
      checkResp(nameQ.pop_front(), expQ.pop_front(), resp, knownQ.pop_front());
    end
    sentValid = cmdValid && reset;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles <= ResetCycles + 20 * (issued + 1)) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout after %0d cycles, responses still outstanding", cycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    arrayOp op;
    int     r;
    reset    = 1'b0;
    cmdValid = 1'b0;
    cmd      = '0;
    mHigh    = 0;
    for (int i = 0; i < ArrayCount; i++) begin
      mAlloc[i] = 1'b0;
      mSize[i]  = 0;
      for (int j = 0; j < ArrayLength; j++) mKnown[i][j] = 1'b0;
    end
    repeat (ResetCycles) @(posedge clock);
    reset <= 1'b1;
    repeat (5) issue("alloc order", opAlloc, 0, 0, 0);         // Fifth runs out
    issue("free", opFree, 2, 0, 0);
    issue("free", opFree, 0, 0, 0);
    repeat (2) issue("alloc reuse", opAlloc, 0, 0, 0);
    issue("pool reset", opReset, 0, 0, 0);
    issue("never allocated", opRead, 1, 0, 0);
    issue("never allocated", opInc, 3, 0, 0);
    issue("alloc", opAlloc, 0, 0, 0);
    repeat (2) issue("double free", opFree, 0, 0, 0);
    issue("read freed", opRead, 0, 0, 0);
    issue("pool reset", opReset, 0, 0, 0);
    issue("alloc", opAlloc, 0, 0, 0);
    issue("write extend", opWrite, 0, 5, 12'h5a5);
    issue("size", opSize, 0, 0, 0);
    for (int i = 0; i <= 6; i++) issue("read bounds", opRead, 0, i, 0);
    issue("alloc", opAlloc, 0, 0, 0);
    repeat (ArrayLength + 1) issue("push", opPush, 1, 0, $random(seed));
    repeat (ArrayLength + 1) issue("pop", opPop, 1, 0, 0);
    repeat (ArrayLength + 1) issue("inc", opInc, 1, 0, 0);
    repeat (ArrayLength + 1) issue("dec", opDec, 1, 0, 0);
    issue("alloc", opAlloc, 0, 0, 0);
    for (int i = 0; i < ArrayLength; i++) issue("fill", opWrite, 2, i, $random(seed));
    repeat (60) begin
      op = arrayOp'(int'(opAdd) + {$random(seed)} % 7);
      issue("arithmetic", op, 2, {$random(seed)} % ArrayLength, $random(seed));
    end
    repeat (400) begin
      r  = {$random(seed)} % 20;
      op = (r > int'(opAnd)) ? opAlloc : arrayOp'(r);   // Extra weight on alloc
      issue("random mix", op, {$random(seed)} % ArrayCount, {$random(seed)} % ArrayLength,
            $random(seed));
    end
    @(posedge clock);
    cmdValid <= 1'b0;
    while (expQ.size() != 0) @(negedge clock);
    repeat (2) @(negedge clock);
    $display("Closing count: %0d compare errors, %0d assertion failures over %0d commands",
             errors, dut0.chk0.failCount, issued);
    if (errors == 0 && dut0.chk0.failCount == 0) $display("sim passed");
    else $display("sim failed");
    $finish;
  end

endmodule

// File: arrayUnit_chk.sv
//--------------------------------------------------------------------------
// Array unit assertions
// Strobe timing and response rules watched on the top level ports
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module arrayUnit_chk (
  input logic               clock,
  input logic               reset,
  input logic               cmdValid,
  input arrayPkg::arrayCmd  cmd,
  input logic               respValid,
  input arrayPkg::arrayResp resp
);
  import arrayPkg::*;

  arrayOp lastOp;                                      // Op behind the visible response
  int     failCount = 0;                               // Assertion failures so far

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      lastOp <= opReset;
    end else begin
      lastOp <= cmd.op;
    end
  end

  noStrobeInReset: assert property (@(posedge clock) !reset |-> !respValid)
    else begin
      $error("respValid high while reset is asserted");
      failCount++;
    end

  strobeFollowsCmd: assert property (@(posedge clock) disable iff (!reset)
    respValid == $past(cmdValid))
    else begin
      $error("respValid does not follow cmdValid by one cycle");
      failCount++;
    end

  allocIdInRange: assert property (@(posedge clock) disable iff (!reset)
    (respValid && lastOp == opAlloc && resp.error == errNone)
      |-> (resp.value < DataWidth'(ArrayCount)))
    else begin
      $error("alloc returned an id outside the pool");
      failCount++;
    end

  errorValueZero: assert property (@(posedge clock) disable iff (!reset)
    (respValid && resp.error != errNone) |-> (resp.value == '0))
    else begin
      $error("error response carries a nonzero value");
      failCount++;
    end

endmodule

bind arrayUnit arrayUnit_chk chk0 (.*);

// File: arrayUnit.sv
//--------------------------------------------------------------------------
// Array memory unit
// Pool of fixed arrays, one command per cycle, registered response
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module arrayUnit (
  input  logic               clock,
  input  logic               reset,
  input  logic               cmdValid,
  input  arrayPkg::arrayCmd  cmd,
  output logic               respValid,
  output arrayPkg::arrayResp resp
);
  import arrayPkg::*;

  logic [ArrayCount-1:0] allocated;
  sizeCount              highWater;
  logic                  canAlloc;
  arrayId                nextId;
  sizeCount              sizes [ArrayCount];
  dataWord               execValue;
  logic                  go;
  arrayDecoded           decoded;

  arrayDecode decode0 (
    .cmdValid  (cmdValid),
    .cmd       (cmd),
    .allocated (allocated),
    .highWater (highWater),
    .canAlloc  (canAlloc),
    .sizes     (sizes),
    .go        (go),
    .decoded   (decoded)
  );

  arrayAllocator allocator0 (
    .clock     (clock),
    .reset     (reset),
    .go        (go),
    .decoded   (decoded),
    .allocated (allocated),
    .highWater (highWater),
    .canAlloc  (canAlloc),
    .nextId    (nextId)
  );

  arrayExecute execute0 (
    .clock     (clock),
    .reset     (reset),
    .go        (go),
    .decoded   (decoded),
    .sizes     (sizes),
    .execValue (execValue)
  );

  arrayResult result0 (
    .clock     (clock),
    .reset     (reset),
    .go        (go),
    .decoded   (decoded),
    .execValue (execValue),
    .nextId    (nextId),
    .respValid (respValid),
    .resp      (resp)
  );

endmodule

// File: arrayResult.sv
//--------------------------------------------------------------------------
// Response stage
// Picks the response value and registers it with its strobe
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module arrayResult (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  go,
  input  arrayPkg::arrayDecoded decoded,
  input  arrayPkg::dataWord     execValue,
  input  arrayPkg::arrayId      nextId,
  output logic                  respValid,
  output arrayPkg::arrayResp    resp
);
  import arrayPkg::*;

  dataWord value;

  always_comb begin
    if (decoded.error != errNone) begin
      value = '0;                                      // Failed ops return 0
    end else begin
      case (decoded.cmd.op)
        opAlloc:         value = dataWord'(nextId);
        opReset, opFree: value = '0;
        default:         value = execValue;
      endcase
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      respValid <= 1'b0;
    end else begin
      respValid <= go;                                 // One cycle after each command
    end
  end

  always_ff @(posedge clock) begin
    if (go) begin
      resp <= '{value: value, error: decoded.error};
    end
  end

endmodule

// File: arrayExecute.sv
//--------------------------------------------------------------------------
// Execute stage
// Element storage and size table, element arithmetic and size updates
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module arrayExecute (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  go,
  input  arrayPkg::arrayDecoded decoded,
  output arrayPkg::sizeCount    sizes [arrayPkg::ArrayCount],
  output arrayPkg::dataWord     execValue
);
  import arrayPkg::*;

  dataWord  storage [ArrayCount][ArrayLength];         // All elements of the pool
  arrayCmd  cmd;
  logic     legal;
  sizeCount curSize;
  sizeCount indexPlusOne;
  elemIndex addr;                                      // Element touched by this op
  dataWord  oldElem;
  dataWord  newElem;
  logic     writeElem;
  sizeCount newSize;

  assign cmd          = decoded.cmd;
  assign legal        = go && (decoded.error == errNone);
  assign curSize      = sizes[cmd.id];
  assign indexPlusOne = sizeCount'(cmd.index) + sizeCount'(1);

  // Push writes just past the top, pop reads the top
  always_comb begin
    case (cmd.op)
      opPush:  addr = elemIndex'(curSize);
      opPop:   addr = elemIndex'(curSize - sizeCount'(1));
      default: addr = cmd.index;
    endcase
  end

  assign oldElem = storage[cmd.id][addr];

  // ------------------------------------------------------------------------
  // Element result, wraps at DataWidth bits
  // ------------------------------------------------------------------------
  always_comb begin
    writeElem = 1'b1;
    case (cmd.op)
      opWrite, opPush:   newElem = cmd.data;
      opAdd, opAddAfter: newElem = oldElem + cmd.data;
      opSub, opSubAfter: newElem = oldElem - cmd.data;
      opOr:              newElem = oldElem | cmd.data;
      opXor:             newElem = oldElem ^ cmd.data;
      opAnd:             newElem = oldElem & cmd.data;
      default: begin
        newElem   = oldElem;
        writeElem = 1'b0;                              // Storage untouched
      end
    endcase
  end

  always_comb begin
    case (cmd.op)
      opWrite:       newSize = (indexPlusOne > curSize) ? indexPlusOne : curSize;
      opInc, opPush: newSize = curSize + sizeCount'(1);
      opDec, opPop:  newSize = curSize - sizeCount'(1);
      opFree:        newSize = '0;                     // Next alloc finds it empty
      default:       newSize = curSize;
    endcase
  end

  always_comb begin
    case (cmd.op)
      opWrite:                               execValue = cmd.data;
      opRead, opPop, opAddAfter, opSubAfter: execValue = oldElem;
      opSize, opInc, opDec, opPush:          execValue = dataWord'(newSize);
      opAdd, opSub, opOr, opXor, opAnd:      execValue = newElem;
      default:                               execValue = '0;
    endcase
  end

  // ------------------------------------------------------------------------
  // State update
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < ArrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (legal) begin
      if (cmd.op == opReset) begin
        for (int i = 0; i < ArrayCount; i++) begin
          sizes[i] <= '0;
        end
      end else if (cmd.op != opAlloc) begin
        sizes[cmd.id] <= newSize;                      // Unchanged for reads
      end
    end
  end

  // Contents survive free and alloc
  always_ff @(posedge clock) begin
    if (legal && writeElem) begin
      storage[cmd.id][addr] <= newElem;
    end
  end

endmodule

// File: arrayDecode.sv
//--------------------------------------------------------------------------
// Command decode
// Checks each command against allocation and size state and picks the
// highest priority error
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module arrayDecode (
  input  logic                            cmdValid,
  input  arrayPkg::arrayCmd               cmd,
  input  logic [arrayPkg::ArrayCount-1:0] allocated,
  input  arrayPkg::sizeCount              highWater,
  input  logic                            canAlloc,
  input  arrayPkg::sizeCount              sizes [arrayPkg::ArrayCount],
  output logic                            go,
  output arrayPkg::arrayDecoded           decoded
);
  import arrayPkg::*;

  sizeCount curSize;
  logic     boundsOp;                                  // Needs index below size
  logic     shrinkOp;                                  // Needs a nonempty array
  logic     growOp;                                    // Needs room for one more
  errorKind error;

  assign go      = cmdValid;
  assign curSize = sizes[cmd.id];

  always_comb begin
    boundsOp = 1'b0;
    shrinkOp = 1'b0;
    growOp   = 1'b0;
    case (cmd.op)
      opRead, opAdd, opAddAfter, opSub, opSubAfter, opOr, opXor, opAnd: begin
        boundsOp = 1'b1;
      end
      opDec, opPop: begin
        shrinkOp = 1'b1;
      end
      opInc, opPush: begin
        growOp = 1'b1;
      end
      default: ;
    endcase
  end

  // Error priority, first match wins
  always_comb begin
    error = errNone;
    if (cmd.op == opReset) begin
      error = errNone;
    end else if (cmd.op == opAlloc) begin
      if (!canAlloc) begin
        error = errOutOfMemory;
      end
    end else if (sizeCount'(cmd.id) >= highWater) begin
      error = errNotAllocated;
    end else if (!allocated[cmd.id]) begin
      error = errFreed;
    end else if (boundsOp && (sizeCount'(cmd.index) >= curSize)) begin
      error = errOutOfBounds;
    end else if (shrinkOp && (curSize == '0)) begin
      error = errEmpty;
    end else if (growOp && (curSize == sizeCount'(ArrayLength))) begin
      error = errFull;
    end
  end

  assign decoded = '{cmd: cmd, error: error};

endmodule

// File: arrayAllocator.sv
//--------------------------------------------------------------------------
// Array allocator
// Tracks allocated arrays, the high-water count and a LIFO of freed ids
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module arrayAllocator (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            go,
  input  arrayPkg::arrayDecoded           decoded,
  output logic [arrayPkg::ArrayCount-1:0] allocated,
  output arrayPkg::sizeCount              highWater,
  output logic                            canAlloc,
  output arrayPkg::arrayId                nextId
);
  import arrayPkg::*;

  arrayId   freeStack [ArrayCount];                    // Freed ids, newest on top
  sizeCount freeTop;                                   // Entries on the stack
  logic     stackEmpty;
  logic     legal;
  logic     doClear;
  logic     doAlloc;
  logic     doFree;

  assign stackEmpty = (freeTop == '0);
  assign canAlloc   = !stackEmpty || (highWater != sizeCount'(ArrayCount));

  // Reuse the most recent free, else take a fresh id
  assign nextId = stackEmpty ? arrayId'(highWater)
                             : freeStack[arrayId'(freeTop - sizeCount'(1))];

  assign legal   = go && (decoded.error == errNone);
  assign doClear = legal && (decoded.cmd.op == opReset);
  assign doAlloc = legal && (decoded.cmd.op == opAlloc);
  assign doFree  = legal && (decoded.cmd.op == opFree);

  // ------------------------------------------------------------------------
  // Allocation state
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated <= '0;
      highWater <= '0;
      freeTop   <= '0;
    end else if (doClear) begin
      allocated <= '0;
      highWater <= '0;
      freeTop   <= '0;
    end else if (doAlloc) begin
      allocated[nextId] <= 1'b1;
      if (stackEmpty) begin
        highWater <= highWater + sizeCount'(1);        // Fresh id consumed
      end else begin
        freeTop <= freeTop - sizeCount'(1);            // Pop reused id
      end
    end else if (doFree) begin
      allocated[decoded.cmd.id] <= 1'b0;
      freeTop                   <= freeTop + sizeCount'(1);
    end
  end

  // At most ArrayCount ids are free at once, so the push never overflows
  always_ff @(posedge clock) begin
    if (doFree) begin
      freeStack[arrayId'(freeTop)] <= decoded.cmd.id;
    end
  end

endmodule

// File: arrayPkg.sv
//--------------------------------------------------------------------------
// Array memory unit definitions
// Pool sizes, element types, opcode and error encodings, command and
// response structs shared by every block of the unit
//--------------------------------------------------------------------------
package arrayPkg;

  localparam int ArrayCount  = 4;                      // Arrays in the pool
  localparam int ArrayLength = 8;                      // Elements per array
  localparam int DataWidth   = 12;                     // Bits per element

  typedef logic [$clog2(ArrayCount)-1:0]  arrayId;     // Array number
  typedef logic [$clog2(ArrayLength)-1:0] elemIndex;   // Element number
  typedef logic [$clog2(ArrayLength):0]   sizeCount;   // Size, 0 to ArrayLength
  typedef logic [DataWidth-1:0]           dataWord;    // Element value

  typedef enum logic [4:0] {
    opReset,                                           // Empty the whole pool
    opAlloc,                                           // Hand out an array
    opFree,                                            // Give an array back
    opWrite,                                           // Store, growing the size
    opRead,
    opSize,
    opInc,
    opDec,
    opPush,
    opPop,
    opAdd,                                             // Returns new element
    opAddAfter,                                        // Returns old element
    opSub,
    opSubAfter,
    opOr,
    opXor,
    opAnd
  } arrayOp;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                   // Id never handed out
    errFreed,                                          // Id handed out, then freed
    errOutOfBounds,                                    // Index not below size
    errEmpty,
    errFull,
    errOutOfMemory                                     // No id left to allocate
  } errorKind;

  // ------------------------------------------------------------------------
  // Command and response payloads
  // ------------------------------------------------------------------------
  typedef struct packed {
    arrayOp   op;
    arrayId   id;
    elemIndex index;
    dataWord  data;
  } arrayCmd;

  typedef struct packed {
    arrayCmd  cmd;
    errorKind error;                                   // Result of all checks
  } arrayDecoded;

  typedef struct packed {
    dataWord  value;
    errorKind error;
  } arrayResp;

endpackage
